/* sys_wb_pkg.sv */
// shared widths, opcode and funct codes, instruction and csr command types, instruction word union
package sys_wb_pkg;

    // datapath widths
    localparam int XLEN       = 64;
    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    // major opcodes handled here
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

    // funct3 codes for SYSTEM and MISC-MEM
    localparam logic [2:0] F3_PRIV    = 3'b000;
    localparam logic [2:0] F3_CSRRW   = 3'b001;
    localparam logic [2:0] F3_CSRRS   = 3'b010;
    localparam logic [2:0] F3_CSRRC   = 3'b011;
    localparam logic [2:0] F3_CSRRWI  = 3'b101;
    localparam logic [2:0] F3_CSRRSI  = 3'b110;
    localparam logic [2:0] F3_CSRRCI  = 3'b111;
    localparam logic [2:0] F3_FENCE   = 3'b000;
    localparam logic [2:0] F3_FENCE_I = 3'b001;

    // funct7 selects the privilege level of the return
    localparam logic [6:0] F7_PRIV_U = 7'b0000000;
    localparam logic [6:0] F7_PRIV_S = 7'b0001000;
    localparam logic [6:0] F7_PRIV_M = 7'b0011000;

    // rs2 field of the privileged group
    localparam logic [4:0] PRIV_RS2_ECALL  = 5'd0;
    localparam logic [4:0] PRIV_RS2_EBREAK = 5'd1;
    localparam logic [4:0] PRIV_RS2_RET    = 5'd2;

    typedef enum logic [3:0] {
        NONE,
        OTHER,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        ECALL,
        EBREAK,
        URET,
        SRET,
        MRET,
        FENCE,
        FENCE_I
    } instr_type_t;

    typedef enum logic [2:0] {
        CSR_CMD_NOPE  = 3'd0,
        CSR_CMD_WRITE = 3'd1,
        CSR_CMD_SET   = 3'd2,
        CSR_CMD_CLEAR = 3'd3,
        CSR_CMD_READ  = 3'd4,
        CSR_CMD_SYS   = 3'd5
    } csr_cmd_t;

    // two readings of the same 32-bit SYSTEM word
    typedef union packed {
        struct packed {
            logic [CSR_ADDR_W-1:0] csr;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } csr_view;
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } priv_view;
    } sys_instr_u;

endpackage

/* sys_decoder.sv */
// instruction word classifier for system, fence and other instructions
module sys_decoder (
    input  logic [sys_wb_pkg::INSTR_W-1:0]    instr_i,
    output sys_wb_pkg::instr_type_t           type_o,
    output logic [sys_wb_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [sys_wb_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [sys_wb_pkg::CSR_ADDR_W-1:0] csr_addr_o,
    output logic                              regfile_we_o
);
    import sys_wb_pkg::*;

    sys_instr_u word;
    logic       rd_nonzero;

    assign word       = instr_i;
    assign rd_nonzero = (word.csr_view.rd != '0);

    // register fields sit at the same place in both views
    assign rd_o       = word.csr_view.rd;
    assign rs1_o      = word.csr_view.rs1;
    assign csr_addr_o = word.csr_view.csr;

    always_comb begin
        type_o       = OTHER;
        regfile_we_o = rd_nonzero;
        case (word.csr_view.opcode)
            OPC_SYSTEM: begin
                // only csr accesses write a register
                regfile_we_o = 1'b0;
                case (word.csr_view.funct3)
                    F3_CSRRW: type_o = CSRRW;
                    F3_CSRRS: type_o = CSRRS;
                    F3_CSRRC: type_o = CSRRC;
                    F3_CSRRWI: type_o = CSRRWI;
                    F3_CSRRSI: type_o = CSRRSI;
                    F3_CSRRCI: type_o = CSRRCI;
                    F3_PRIV: begin
                        type_o = NONE;
                        if (word.priv_view.rs2 == PRIV_RS2_RET) begin
                            case (word.priv_view.funct7)
                                F7_PRIV_U: type_o = URET;
                                F7_PRIV_S: type_o = SRET;
                                F7_PRIV_M: type_o = MRET;
                                default:   type_o = NONE;
                            endcase
                        end else if (word.priv_view.funct7 == F7_PRIV_U) begin
                            if (word.priv_view.rs2 == PRIV_RS2_ECALL) begin
                                type_o = ECALL;
                            end else if (word.priv_view.rs2 == PRIV_RS2_EBREAK) begin
                                type_o = EBREAK;
                            end
                        end
                    end
                    default: type_o = NONE;
                endcase
                if (word.csr_view.funct3 != F3_PRIV && type_o != NONE) begin
                    regfile_we_o = rd_nonzero;
                end
            end
            OPC_MISC_MEM: begin
                regfile_we_o = 1'b0;
                case (word.csr_view.funct3)
                    F3_FENCE:   type_o = FENCE;
                    F3_FENCE_I: type_o = FENCE_I;
                    default:    type_o = NONE;
                endcase
            end
            default: begin
                // everything else just writes back its result
                type_o       = OTHER;
                regfile_we_o = rd_nonzero;
            end
        endcase
    end

endmodule

/* exe_wb_reg.sv */
// execute to writeback pipeline register with stall and flush
module exe_wb_reg (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              stall_i,
    input  logic                              flush_i,
    input  logic                              valid_i,
    input  sys_wb_pkg::instr_type_t           type_i,
    input  logic [sys_wb_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [sys_wb_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [sys_wb_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  logic                              regfile_we_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       pc_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       result_i,
    input  logic                              xcpt_valid_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       xcpt_cause_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       xcpt_origin_i,
    output logic                              valid_o,
    output sys_wb_pkg::instr_type_t           type_o,
    output logic [sys_wb_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [sys_wb_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [sys_wb_pkg::CSR_ADDR_W-1:0] csr_addr_o,
    output logic                              regfile_we_o,
    output logic [sys_wb_pkg::XLEN-1:0]       pc_o,
    output logic [sys_wb_pkg::XLEN-1:0]       result_o,
    output logic                              xcpt_valid_o,
    output logic [sys_wb_pkg::XLEN-1:0]       xcpt_cause_o,
    output logic [sys_wb_pkg::XLEN-1:0]       xcpt_origin_o
);

    // flush wins over stall
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    // payload only moves when the stage advances
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            type_o        <= type_i;
            rd_o          <= rd_i;
            rs1_o         <= rs1_i;
            csr_addr_o    <= csr_addr_i;
            regfile_we_o  <= regfile_we_i;
            pc_o          <= pc_i;
            result_o      <= result_i;
            xcpt_valid_o  <= xcpt_valid_i;
            xcpt_cause_o  <= xcpt_cause_i;
            xcpt_origin_o <= xcpt_origin_i;
        end
    end

endmodule

/* wb_csr_stage.sv */
// writeback stage with csr request, register write data and control flags
module wb_csr_stage (
    input  logic                              valid_i,
    input  sys_wb_pkg::instr_type_t           type_i,
    input  logic [sys_wb_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [sys_wb_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [sys_wb_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  logic                              regfile_we_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       pc_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       result_i,
    input  logic                              xcpt_valid_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       xcpt_cause_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       xcpt_origin_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       csr_rw_rdata_i,
    output logic [sys_wb_pkg::CSR_ADDR_W-1:0] csr_rw_addr_o,
    output sys_wb_pkg::csr_cmd_t              csr_rw_cmd_o,
    output logic [sys_wb_pkg::XLEN-1:0]       csr_rw_data_o,
    output logic                              csr_exception_o,
    output logic                              csr_retire_o,
    output logic [sys_wb_pkg::XLEN-1:0]       csr_xcpt_cause_o,
    output logic [sys_wb_pkg::XLEN-1:0]       csr_pc_o,
    output logic                              wb_we_o,
    output logic [sys_wb_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [sys_wb_pkg::XLEN-1:0]       wb_data_o,
    output logic                              ecall_taken_o,
    output logic                              fence_o
);
    import sys_wb_pkg::*;

    csr_cmd_t          csr_cmd;
    logic [XLEN-1:0]   csr_data;
    logic [XLEN-1:0]   zimm;
    logic              rs1_zero;
    logic              csr_ena;

    assign zimm     = {{(XLEN-REG_ADDR_W){1'b0}}, rs1_i};
    assign rs1_zero = (rs1_i == '0);

    // command per type, a zero rs1 turns set and clear into a plain read
    always_comb begin
        csr_cmd  = CSR_CMD_NOPE;
        csr_data = '0;
        case (type_i)
            CSRRW, CSRRWI: csr_cmd = CSR_CMD_WRITE;
            CSRRS, CSRRSI: csr_cmd = rs1_zero ? CSR_CMD_READ : CSR_CMD_SET;
            CSRRC, CSRRCI: csr_cmd = rs1_zero ? CSR_CMD_READ : CSR_CMD_CLEAR;
            ECALL, EBREAK, URET, SRET, MRET, FENCE: csr_cmd = CSR_CMD_SYS;
            default: csr_cmd = CSR_CMD_NOPE;
        endcase
        case (type_i)
            CSRRW, CSRRS, CSRRC: csr_data = result_i;
            CSRRWI, CSRRSI, CSRRCI: csr_data = zimm;
            default: csr_data = '0;
        endcase
    end

    assign csr_ena = valid_i && (csr_cmd != CSR_CMD_NOPE);

    // csr request, origin goes out as data to help the trap handler
    assign csr_rw_addr_o    = csr_ena ? csr_addr_i : '0;
    assign csr_rw_cmd_o     = csr_ena ? csr_cmd : CSR_CMD_NOPE;
    assign csr_rw_data_o    = csr_ena ? csr_data : xcpt_origin_i;
    assign csr_exception_o  = valid_i && xcpt_valid_i;
    assign csr_retire_o     = valid_i && !xcpt_valid_i;
    assign csr_xcpt_cause_o = xcpt_cause_i;
    assign csr_pc_o         = pc_i;

    // register write port
    assign wb_we_o   = valid_i && regfile_we_i;
    assign wb_rd_o   = rd_i;
    assign wb_data_o = csr_ena ? csr_rw_rdata_i : result_i;

    // flags for the control unit
    assign ecall_taken_o = valid_i && (type_i == ECALL || type_i == EBREAK);
    assign fence_o       = valid_i && (type_i == FENCE || type_i == FENCE_I);

endmodule

/* sys_wb_top.sv */
// top level with decoder, execute to writeback register and writeback stage
module sys_wb_top (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              instr_valid_i,
    input  logic [sys_wb_pkg::INSTR_W-1:0]    instr_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       pc_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       result_i,
    input  logic                              xcpt_valid_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       xcpt_cause_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       xcpt_origin_i,
    input  logic                              stall_i,
    input  logic                              flush_i,
    input  logic [sys_wb_pkg::XLEN-1:0]       csr_rw_rdata_i,
    output logic [sys_wb_pkg::CSR_ADDR_W-1:0] csr_rw_addr_o,
    output sys_wb_pkg::csr_cmd_t              csr_rw_cmd_o,
    output logic [sys_wb_pkg::XLEN-1:0]       csr_rw_data_o,
    output logic                              csr_exception_o,
    output logic                              csr_retire_o,
    output logic [sys_wb_pkg::XLEN-1:0]       csr_xcpt_cause_o,
    output logic [sys_wb_pkg::XLEN-1:0]       csr_pc_o,
    output logic                              wb_we_o,
    output logic [sys_wb_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [sys_wb_pkg::XLEN-1:0]       wb_data_o,
    output logic                              ecall_taken_o,
    output logic                              fence_o
);
    import sys_wb_pkg::*;

    // decoder outputs
    instr_type_t           dec_type;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [CSR_ADDR_W-1:0] dec_csr_addr;
    logic                  dec_we;

    // registered record in writeback
    logic                  wb_valid;
    instr_type_t           wb_type;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [REG_ADDR_W-1:0] wb_rs1;
    logic [CSR_ADDR_W-1:0] wb_csr_addr;
    logic                  wb_regfile_we;
    logic [XLEN-1:0]       wb_pc;
    logic [XLEN-1:0]       wb_result;
    logic                  wb_xcpt_valid;
    logic [XLEN-1:0]       wb_xcpt_cause;
    logic [XLEN-1:0]       wb_xcpt_origin;

    sys_decoder u_decoder (
        .instr_i      (instr_i),
        .type_o       (dec_type),
        .rd_o         (dec_rd),
        .rs1_o        (dec_rs1),
        .csr_addr_o   (dec_csr_addr),
        .regfile_we_o (dec_we)
    );

    exe_wb_reg u_exe_wb_reg (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .valid_i       (instr_valid_i),
        .type_i        (dec_type),
        .rd_i          (dec_rd),
        .rs1_i         (dec_rs1),
        .csr_addr_i    (dec_csr_addr),
        .regfile_we_i  (dec_we),
        .pc_i          (pc_i),
        .result_i      (result_i),
        .xcpt_valid_i  (xcpt_valid_i),
        .xcpt_cause_i  (xcpt_cause_i),
        .xcpt_origin_i (xcpt_origin_i),
        .valid_o       (wb_valid),
        .type_o        (wb_type),
        .rd_o          (wb_rd),
        .rs1_o         (wb_rs1),
        .csr_addr_o    (wb_csr_addr),
        .regfile_we_o  (wb_regfile_we),
        .pc_o          (wb_pc),
        .result_o      (wb_result),
        .xcpt_valid_o  (wb_xcpt_valid),
        .xcpt_cause_o  (wb_xcpt_cause),
        .xcpt_origin_o (wb_xcpt_origin)
    );

    wb_csr_stage u_wb_csr_stage (
        .valid_i          (wb_valid),
        .type_i           (wb_type),
        .rd_i             (wb_rd),
        .rs1_i            (wb_rs1),
        .csr_addr_i       (wb_csr_addr),
        .regfile_we_i     (wb_regfile_we),
        .pc_i             (wb_pc),
        .result_i         (wb_result),
        .xcpt_valid_i     (wb_xcpt_valid),
        .xcpt_cause_i     (wb_xcpt_cause),
        .xcpt_origin_i    (wb_xcpt_origin),
        .csr_rw_rdata_i   (csr_rw_rdata_i),
        .csr_rw_addr_o    (csr_rw_addr_o),
        .csr_rw_cmd_o     (csr_rw_cmd_o),
        .csr_rw_data_o    (csr_rw_data_o),
        .csr_exception_o  (csr_exception_o),
        .csr_retire_o     (csr_retire_o),
        .csr_xcpt_cause_o (csr_xcpt_cause_o),
        .csr_pc_o         (csr_pc_o),
        .wb_we_o          (wb_we_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o),
        .ecall_taken_o    (ecall_taken_o),
        .fence_o          (fence_o)
    );

endmodule

/* tb_sys_wb.sv */
// directed testbench for the system writeback slice with expected-value model, stall and flush stream
module tb_sys_wb;
    import sys_wb_pkg::*;

    localparam logic [63:0] RDATA_KEY = 64'h5a5a_0f0f_3c3c_a5a5;
    // about four times the roughly 480 cycles that the tests take
    localparam int MAX_CYCLES = 2000;

    logic        clk_i, rstn_i, instr_valid_i, xcpt_valid_i, stall_i, flush_i;
    logic [31:0] instr_i;
    logic [63:0] pc_i, result_i, xcpt_cause_i, xcpt_origin_i, csr_rw_rdata_i;
    logic [11:0] csr_rw_addr_o;
    csr_cmd_t    csr_rw_cmd_o;
    logic [63:0] csr_rw_data_o, csr_xcpt_cause_o, csr_pc_o, wb_data_o;
    logic        csr_exception_o, csr_retire_o, wb_we_o, ecall_taken_o, fence_o;
    logic [4:0]  wb_rd_o;

    // record the writeback stage should be holding
    logic        m_valid, m_xv;
    logic [31:0] m_word;
    logic [63:0] m_pc, m_res, m_cause, m_org;

    string       test_name;
    int          errors, test_errors, tests_run;
    int          cycles = 0;

    sys_wb_top uut (.*);

    // csr file stand-in whose reply depends only on the address
    assign csr_rw_rdata_i = {52'b0, csr_rw_addr_o} ^ RDATA_KEY;

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] encode(input logic [11:0] hi, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {hi, rs1, f3, rd, opc};
    endfunction

    task automatic check_field(input string field, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("Fail %s %s expected %h actual %h", test_name, field, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d mismatches", test_name, test_errors);
        end
    endtask

    // expected outputs from the writeback rules applied to the held record
    task automatic check_outputs();
        logic [6:0]  opc, f7;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3, cmd, exp_cmd;
        logic [63:0] data;
        logic        wr, en, ecall, fence;
        opc   = m_word[6:0];
        rd    = m_word[11:7];
        f3    = m_word[14:12];
        rs1   = m_word[19:15];
        rs2   = m_word[24:20];
        f7    = m_word[31:25];
        cmd   = CSR_CMD_NOPE;
        data  = '0;
        wr    = 1'b0;
        ecall = 1'b0;
        fence = 1'b0;
        if (opc == OPC_SYSTEM) begin
            if (f3 == F3_CSRRW || f3 == F3_CSRRWI) begin
                cmd = CSR_CMD_WRITE;
            end else if (f3 == F3_CSRRS || f3 == F3_CSRRSI) begin
                cmd = (rs1 == 5'd0) ? CSR_CMD_READ : CSR_CMD_SET;
            end else if (f3 == F3_CSRRC || f3 == F3_CSRRCI) begin
                cmd = (rs1 == 5'd0) ? CSR_CMD_READ : CSR_CMD_CLEAR;
            end else if (f3 == F3_PRIV && f7 == F7_PRIV_U && rs2 < 5'd2) begin
                cmd   = CSR_CMD_SYS;
                ecall = 1'b1;
            end else if (f3 == F3_PRIV && rs2 == 5'd2 &&
                         (f7 == F7_PRIV_U || f7 == F7_PRIV_S || f7 == F7_PRIV_M)) begin
                cmd = CSR_CMD_SYS;
            end
            // csr forms write rd and funct3 bit 2 picks zimm over the result
            if (cmd != CSR_CMD_NOPE && f3 != F3_PRIV) begin
                wr   = (rd != 5'd0);
                data = f3[2] ? {59'b0, rs1} : m_res;
            end
        end else if (opc == OPC_MISC_MEM) begin
            fence = (f3 == F3_FENCE || f3 == F3_FENCE_I);
            if (f3 == F3_FENCE) begin
                cmd = CSR_CMD_SYS;
            end
        end else begin
            wr = (rd != 5'd0);
        end
        en      = m_valid && (cmd != CSR_CMD_NOPE);
        exp_cmd = en ? cmd : CSR_CMD_NOPE;
        check_field("cmd", 64'(exp_cmd), 64'(csr_rw_cmd_o));
        check_field("addr", 64'(en ? m_word[31:20] : 12'd0), 64'(csr_rw_addr_o));
        check_field("csr_data", en ? data : m_org, csr_rw_data_o);
        check_field("wb_data", en ? ({52'b0, m_word[31:20]} ^ RDATA_KEY) : m_res, wb_data_o);
        check_field("wb_we", 64'(m_valid && wr), 64'(wb_we_o));
        check_field("wb_rd", 64'(rd), 64'(wb_rd_o));
        check_field("retire", 64'(m_valid && !m_xv), 64'(csr_retire_o));
        check_field("exception", 64'(m_valid && m_xv), 64'(csr_exception_o));
        check_field("cause", m_cause, csr_xcpt_cause_o);
        check_field("pc", m_pc, csr_pc_o);
        check_field("ecall", 64'(m_valid && ecall), 64'(ecall_taken_o));
        check_field("fence", 64'(m_valid && fence), 64'(fence_o));
    endtask

    // present one record on a rising edge and check after the edge that takes it
    task automatic step(input logic [31:0] w, input logic v, input logic [63:0] res,
                        input logic xv, input logic st, input logic fl);
        logic [63:0] pc, cause, org;
        pc    = {$urandom, $urandom} & ~64'h3;
        cause = 64'($urandom_range(15, 0));
        org   = {$urandom, $urandom};
        @(posedge clk_i);
        instr_valid_i <= v;
        instr_i       <= w;
        result_i      <= res;
        xcpt_valid_i  <= xv;
        xcpt_cause_i  <= cause;
        xcpt_origin_i <= org;
        pc_i          <= pc;
        stall_i       <= st;
        flush_i       <= fl;
        @(posedge clk_i);
        if (fl) begin
            m_valid = 1'b0;
        end else if (!st) begin
            m_valid = v;
        end
        if (!st) begin
            m_word  = w;
            m_res   = res;
            m_xv    = xv;
            m_cause = cause;
            m_org   = org;
            m_pc    = pc;
        end
        @(negedge clk_i);
        check_outputs();
    endtask

    task automatic reset_state();
        start_test("reset");
        @(negedge clk_i);
        check_field("retire", 64'd0, 64'(csr_retire_o));
        check_field("exception", 64'd0, 64'(csr_exception_o));
        check_field("wb_we", 64'd0, 64'(wb_we_o));
        check_field("ecall", 64'd0, 64'(ecall_taken_o));
        check_field("fence", 64'd0, 64'(fence_o));
        check_field("cmd", 64'(CSR_CMD_NOPE), 64'(csr_rw_cmd_o));
        check_field("addr", 64'd0, 64'(csr_rw_addr_o));
        finish_test();
    endtask

    // each form with rs1 zero or not and rd zero or not
    task automatic csr_forms(input string name, input logic [2:0] f3_w,
                             input logic [2:0] f3_s, input logic [2:0] f3_c);
        logic [2:0] ops [3];
        logic [4:0] rs1;
        ops = '{f3_w, f3_s, f3_c};
        start_test(name);
        foreach (ops[i]) begin
            for (int k = 0; k < 4; k++) begin
                rs1 = k[0] ? 5'($urandom_range(31, 1)) : 5'd0;
                step(encode(12'($urandom), rs1, ops[i], k[1] ? 5'd7 : 5'd0, OPC_SYSTEM),
                     1'b1, {$urandom, $urandom}, 1'b0, 1'b0, 1'b0);
            end
        end
        finish_test();
    endtask

    task automatic system_types();
        logic [11:0] priv_hi [5];
        priv_hi = '{12'h000, 12'h001, 12'h002, 12'h102, 12'h302};
        start_test("system");
        foreach (priv_hi[i]) begin
            step(encode(priv_hi[i], 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM), 1'b1,
                 {$urandom, $urandom}, 1'b0, 1'b0, 1'b0);
        end
        step(encode(12'h0ff, 5'd0, F3_FENCE, 5'd0, OPC_MISC_MEM), 1'b1, 64'h11, 1'b0, 1'b0, 1'b0);
        step(encode(12'h000, 5'd0, F3_FENCE_I, 5'd0, OPC_MISC_MEM), 1'b1, 64'h22, 1'b0, 1'b0, 1'b0);
        finish_test();
    endtask

    task automatic other_and_exception();
        start_test("other_and_exception");
        step(encode(12'h123, 5'd4, 3'd0, 5'd9, 7'b0110011), 1'b1, 64'hbeef, 1'b0, 1'b0, 1'b0);
        step(encode(12'h305, 5'd3, F3_CSRRW, 5'd2, OPC_SYSTEM), 1'b1, 64'h77, 1'b1, 1'b0, 1'b0);
        step(encode(12'h340, 5'd1, 3'b100, 5'd6, OPC_SYSTEM), 1'b1, 64'h99, 1'b0, 1'b0, 1'b0);
        step(encode(12'h020, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM), 1'b1, 64'h55, 1'b0, 1'b0, 1'b0);
        finish_test();
    endtask

    // random records with random stall and flush
    task automatic stall_flush_stream();
        logic [11:0] priv_hi [5];
        logic [31:0] w;
        int          kind, mode;
        priv_hi = '{12'h000, 12'h001, 12'h002, 12'h102, 12'h302};
        start_test("stall_flush_stream");
        for (int i = 0; i < 200; i++) begin
            kind = $urandom_range(3, 0);
            mode = $urandom_range(5, 0);
            case (kind)
                0: w = encode(12'($urandom), 5'($urandom), 3'($urandom), 5'($urandom), OPC_SYSTEM);
                1: w = encode(priv_hi[$urandom_range(4, 0)], 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM);
                2: w = encode(12'($urandom), 5'd0, 3'($urandom), 5'd0, OPC_MISC_MEM);
                default: w = $urandom;
            endcase
            // mode 2 raises stall and flush together
            step(w, $urandom_range(3, 0) != 0, {$urandom, $urandom}, $urandom_range(7, 0) == 0,
                 mode == 0 || mode == 2, mode == 1 || mode == 2);
        end
        finish_test();
    endtask

    initial begin
        void'($urandom(97));
        errors        = 0;
        tests_run     = 0;
        rstn_i        <= 1'b0;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        pc_i          <= '0;
        result_i      <= '0;
        xcpt_valid_i  <= 1'b0;
        xcpt_cause_i  <= '0;
        xcpt_origin_i <= '0;
        stall_i       <= 1'b0;
        flush_i       <= 1'b0;
        // payload keeps loading the zero inputs during reset
        m_valid = 1'b0;
        m_xv    = 1'b0;
        m_word  = '0;
        m_pc    = '0;
        m_res   = '0;
        m_cause = '0;
        m_org   = '0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;
        reset_state();
        csr_forms("csr_register", F3_CSRRW, F3_CSRRS, F3_CSRRC);
        csr_forms("csr_immediate", F3_CSRRWI, F3_CSRRSI, F3_CSRRCI);
        system_types();
        other_and_exception();
        stall_flush_stream();
        $display("tests run %0d, mismatches %0d", tests_run, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
sys_wb_pkg.sv
sys_decoder.sv
exe_wb_reg.sv
wb_csr_stage.sv
sys_wb_top.sv
tb_sys_wb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for failures
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sys_wb -f src.f > build.log 2>&1 \
    && ./obj_dir/Vtb_sys_wb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
